// ==== list.f ====
+incdir+sim
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/mips_core.sv
sim/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/hazard_unit.sv
  - src/mips_core.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_mips_core.sv

// ==== sim/tb_programs.svh ====
// Test program encoders
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic word_t rtype_word(input logic [5:0] fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt,
                                     input logic [4:0] sh);
    return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic reset_program();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'd5));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'd7));
    prog.push_back(rtype_word(FN_ADDU, 3, 1, 2, 0));
endtask

// Each result feeds the next one or two, so both forwarding paths are used
task automatic alu_chain_program();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] imm_c;
    logic [4:0]  sh;
    imm_a = 16'($urandom);
    imm_b = 16'($urandom);
    imm_c = 16'($urandom);
    sh    = 5'($urandom);
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, imm_a));
    prog.push_back(itype_word(OP_ADDIU, 2, 1, imm_b));
    prog.push_back(rtype_word(FN_ADDU, 3, 1, 2, 0));
    prog.push_back(rtype_word(FN_SUBU, 4, 3, 1, 0));
    prog.push_back(rtype_word(FN_AND, 5, 4, 2, 0));
    prog.push_back(rtype_word(FN_OR, 6, 5, 3, 0));
    prog.push_back(rtype_word(FN_SLT, 7, 4, 1, 0));
    prog.push_back(rtype_word(FN_SLL, 8, 0, 3, sh));
    prog.push_back(rtype_word(FN_SLT, 9, 1, 4, 0));
    prog.push_back(itype_word(OP_ADDIU, 10, 8, imm_c));
endtask

task automatic memory_program();
    logic [15:0] value;
    value = 16'($urandom);
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'h0040));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, value));
    prog.push_back(itype_word(OP_SW, 2, 1, 16'd4));
    prog.push_back(itype_word(OP_LW, 3, 1, 16'd4));
    prog.push_back(rtype_word(FN_ADDU, 4, 3, 2, 0));   // Load-use on rs
    prog.push_back(itype_word(OP_LW, 5, 1, 16'd4));
    prog.push_back(itype_word(OP_SW, 5, 1, 16'd8));    // Load-use on store data
    prog.push_back(itype_word(OP_LW, 6, 1, 16'd8));
    prog.push_back(rtype_word(FN_SUBU, 7, 6, 0, 0));
    prog.push_back(itype_word(OP_ADDIU, 8, 7, 16'd3));
    prog.push_back(itype_word(OP_LW, 9, 1, 16'd8));
    prog.push_back(rtype_word(FN_ADDU, 10, 9, 8, 0));  // Rt comes from writeback during the stall
endtask

task automatic branch_program();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'd3));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'd3));
    prog.push_back(itype_word(OP_BEQ, 2, 1, 16'd3));   // Taken to word 6
    prog.push_back(itype_word(OP_ADDIU, 3, 0, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 3, 0, 16'd2));
    prog.push_back(itype_word(OP_ADDIU, 3, 0, 16'd3));
    prog.push_back(itype_word(OP_BNE, 2, 1, 16'd2));   // Not taken
    prog.push_back(itype_word(OP_ADDIU, 4, 0, 16'd4));
    prog.push_back(itype_word(OP_BNE, 1, 4, 16'd2));   // Taken to word 11
    prog.push_back(itype_word(OP_ADDIU, 5, 0, 16'd5));
    prog.push_back(itype_word(OP_ADDIU, 5, 0, 16'd6));
    prog.push_back(itype_word(OP_BEQ, 0, 4, 16'd1));   // Not taken
    prog.push_back(itype_word(OP_ADDIU, 6, 4, 16'd1));
endtask

task automatic zero_reg_program();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 0, 0, 16'd77));
    prog.push_back(rtype_word(FN_ADDU, 1, 0, 0, 0));
    prog.push_back(32'h0800_0010);                     // Unsupported jump
    prog.push_back(rtype_word(6'h3e, 4, 1, 1, 0));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'd9));
    prog.push_back(rtype_word(FN_OR, 3, 2, 0, 0));
endtask

`endif

// ==== sim/tb_mips_core.sv ====
// MIPS core testbench
`default_nettype none

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int DRAIN_CYCLES = 200;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  prog_we;
    word_t prog_addr;
    word_t prog_data;
    wb_t   retire;

    word_t prog[$];
    wb_t   exp_q[$];

    `include "tb_programs.svh"

    always #10 clk = ~clk;

    mips_core i_mips_core (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .prog_we_i   (prog_we),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .retire_o    (retire)
    );

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, act, exp));
        end
    endtask

    // Rd and data only matter for instructions that write a register
    task automatic compare_wb(input wb_t act, input wb_t exp);
        logic ok;
        ok = act.valid === exp.valid && act.pc === exp.pc && act.reg_write === exp.reg_write;
        if (exp.reg_write) begin
            ok = ok && act.rd === exp.rd && act.data === exp.data;
        end
        if (!ok) begin
            report_mismatch($sformatf("retire pc %h rd %0d data %h, expected pc %h rd %0d data %h",
                act.pc, act.rd, act.data, exp.pc, exp.rd, exp.data));
        end
    endtask

    // Unused words hold an unknown opcode
    function automatic word_t fill_word(input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {6'h3f, 2'b01, a, ~a, a ^ 8'h5a};
    endfunction

    // Sequential ISA model that queues one record per executed instruction
    task automatic build_expected();
        word_t      regs [32];
        word_t      dmem [DMEM_DEPTH];
        word_t      pc;
        word_t      next_pc;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      addr;
        word_t      res;
        wb_t        rec;
        logic [5:0] op;
        reg_addr_t  dest;
        logic       known;
        logic       writes;
        int         steps;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        exp_q.delete();
        pc = '0;
        steps = 0;
        while ((pc >> 2) < prog.size() && steps < 1000) begin
            instr   = prog[pc >> 2];
            op      = instr[31:26];
            a       = regs[instr[25:21]];
            b       = regs[instr[20:16]];
            imm     = {{16{instr[15]}}, instr[15:0]};
            addr    = a + imm;
            next_pc = pc + 32'd4;
            known   = 1'b1;
            writes  = 1'b0;
            dest    = '0;
            res     = '0;
            case (op)
                OP_RTYPE: begin
                    writes = 1'b1;
                    dest   = instr[15:11];
                    case (instr[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << instr[10:6];
                        default: known = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    writes = 1'b1;
                    dest   = instr[20:16];
                    res    = addr;
                end
                OP_LW: begin
                    writes = 1'b1;
                    dest   = instr[20:16];
                    res    = dmem[(addr >> 2) % DMEM_DEPTH];
                end
                OP_SW: dmem[(addr >> 2) % DMEM_DEPTH] = b;
                OP_BEQ: if (a == b) next_pc = pc + 32'd4 + (imm << 2);
                OP_BNE: if (a != b) next_pc = pc + 32'd4 + (imm << 2);
                default: known = 1'b0;
            endcase
            if (known) begin
                rec.valid     = 1'b1;
                rec.pc        = pc;
                rec.reg_write = writes;
                rec.rd        = dest;
                rec.data      = res;
                exp_q.push_back(rec);
                if (writes && dest != '0) regs[dest] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic load_and_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog_we   <= 1'b1;
            prog_addr <= word_t'(i * 4);
            prog_data <= (i < prog.size()) ? prog[i] : fill_word(i);
            @(posedge clk);
        end
        prog_we <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input string name);
        int waited;
        build_expected();
        load_and_reset();
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("timeout in %s test, %0d retires never arrived", name,
                exp_q.size()));
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk); // Late or extra retires are caught by the monitor
        end
        $display("Test %s finished at %0t ns", name, $time);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            compare_flag(retire.valid, 1'b0, "retire valid during reset");
        end else if (retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("unexpected retire from pc 0x%08h", retire.pc));
            end else begin
                compare_wb(retire, exp_q.pop_front());
            end
        end
    end

    task automatic test_reset();
        reset_program();
        run_program("reset");
    endtask

    task automatic test_alu_forwarding();
        alu_chain_program();
        run_program("alu");
    endtask

    task automatic test_load_store();
        memory_program();
        run_program("memory");
    endtask

    task automatic test_branches();
        branch_program();
        run_program("branch");
    endtask

    task automatic test_zero_reg_unknown();
        zero_reg_program();
        run_program("zero register");
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(28));
        test_reset();
        test_alu_forwarding();
        test_load_store();
        test_branches();
        test_zero_reg_unknown();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
// Five stage MIPS core
`default_nettype none

module mips_core (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  wire logic            prog_we_i,
    input  wire mips_pkg::word_t prog_addr_i,
    input  wire mips_pkg::word_t prog_data_i,
    output mips_pkg::wb_t        retire_o
);
    import mips_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    id_ex_t    ex_stage;
    ex_mem_t   ex_mem;
    wb_t       wb;
    redirect_t redirect;
    word_t     mem_fwd;
    logic      stall;
    logic      flush;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    fetch_stage i_fetch_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .if_id_o     (if_id)
    );

    decode_stage i_decode_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall),
        .flush_i (flush),
        .if_id_i (if_id),
        .wb_i    (wb),
        .id_ex_o (id_ex)
    );

    execute_stage i_execute_stage (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush),
        .id_ex_i    (id_ex),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .mem_fwd_i  (mem_fwd),
        .wb_i       (wb),
        .ex_stage_o (ex_stage),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect)
    );

    memory_stage i_memory_stage (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ex_mem_i  (ex_mem),
        .mem_fwd_o (mem_fwd),
        .wb_o      (wb)
    );

    hazard_unit i_hazard_unit (
        .ex_stage_i (ex_stage),
        .ex_mem_i   (ex_mem),
        .wb_i       (wb),
        .redirect_i (redirect),
        .stall_o    (stall),
        .flush_o    (flush),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

    assign retire_o = wb;

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// Hazard detection and forwarding
`default_nettype none

module hazard_unit (
    input  wire mips_pkg::id_ex_t    ex_stage_i,
    input  wire mips_pkg::ex_mem_t   ex_mem_i,
    input  wire mips_pkg::wb_t       wb_i,
    input  wire mips_pkg::redirect_t redirect_i,
    output logic                     stall_o,
    output logic                     flush_o,
    output mips_pkg::fwd_sel_e       fwd_a_o,
    output mips_pkg::fwd_sel_e       fwd_b_o
);
    import mips_pkg::*;

    logic uses_rt;

    // Memory stage is younger than writeback so it wins
    function automatic fwd_sel_e pick(input reg_addr_t src);
        if (src != '0 && ex_mem_i.valid && ex_mem_i.reg_write && ex_mem_i.rd == src) begin
            return FWD_MEM;
        end else if (src != '0 && wb_i.valid && wb_i.reg_write && wb_i.rd == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign uses_rt = !ex_stage_i.imm_sel || ex_stage_i.mem_write;

    always_comb begin
        fwd_a_o = pick(ex_stage_i.rs);
        fwd_b_o = pick(ex_stage_i.rt);
    end

    assign stall_o = ex_stage_i.valid && ex_mem_i.valid && ex_mem_i.mem_read &&
                     (ex_mem_i.rd != '0) &&
                     (ex_stage_i.rs == ex_mem_i.rd || (uses_rt && ex_stage_i.rt == ex_mem_i.rd));
    assign flush_o = redirect_i.taken;

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
// Data memory and writeback register
`default_nettype none

module memory_stage (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire mips_pkg::ex_mem_t ex_mem_i,
    output mips_pkg::word_t        mem_fwd_o,
    output mips_pkg::wb_t          wb_o
);
    import mips_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    word_t              dmem [DMEM_DEPTH];
    word_t              load_data;
    logic [DMEM_AW-1:0] idx;

    assign idx       = ex_mem_i.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[idx];
    assign mem_fwd_o = ex_mem_i.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_i.valid && ex_mem_i.mem_write) begin
            dmem[idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid     <= ex_mem_i.valid;
            wb_o.pc        <= ex_mem_i.pc;
            wb_o.reg_write <= ex_mem_i.reg_write;
            wb_o.rd        <= ex_mem_i.rd;
            wb_o.data      <= ex_mem_i.mem_read ? load_data : ex_mem_i.alu_result;
        end
    end

    a_no_ld_st: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ex_mem_i.valid && ex_mem_i.mem_read && ex_mem_i.mem_write));

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// Execute stage
`default_nettype none

module execute_stage (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               flush_i,
    input  wire mips_pkg::id_ex_t   id_ex_i,
    input  wire mips_pkg::fwd_sel_e fwd_a_i,
    input  wire mips_pkg::fwd_sel_e fwd_b_i,
    input  wire mips_pkg::word_t    mem_fwd_i,
    input  wire mips_pkg::wb_t      wb_i,
    output mips_pkg::id_ex_t        ex_stage_o,
    output mips_pkg::ex_mem_t       ex_mem_o,
    output mips_pkg::redirect_t     redirect_o
);
    import mips_pkg::*;

    id_ex_t  ex_q;
    ex_mem_t mem_q;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_a;
    word_t   alu_b;
    word_t   result;
    logic    load_use;

    // A load in the memory register holds this instruction back one cycle
    assign load_use = ex_q.valid && mem_q.valid && mem_q.mem_read && (mem_q.rd != '0) &&
                      (ex_q.rs == mem_q.rd ||
                       ((!ex_q.imm_sel || ex_q.mem_write) && ex_q.rt == mem_q.rd));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_q.valid <= 1'b0;
        end else if (flush_i) begin
            ex_q.valid <= 1'b0;
        end else if (!load_use) begin
            ex_q <= id_ex_i;
        end else begin
            ex_q.rs_data <= op_a; // The writeback source is gone after the hold
            ex_q.rt_data <= op_b;
        end
    end

    always_comb begin
        case (fwd_a_i)
            FWD_MEM: op_a = mem_fwd_i;
            FWD_WB:  op_a = wb_i.data;
            default: op_a = ex_q.rs_data;
        endcase
        case (fwd_b_i)
            FWD_MEM: op_b = mem_fwd_i;
            FWD_WB:  op_b = wb_i.data;
            default: op_b = ex_q.rt_data;
        endcase
    end

    assign alu_a = ex_q.shift_sel ? {27'd0, ex_q.shamt} : op_a;
    assign alu_b = ex_q.imm_sel ? ex_q.imm : op_b;

    always_comb begin
        case (ex_q.alu_op)
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR:  result = alu_a | alu_b;
            ALU_SLT: result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLL: result = alu_b << alu_a[4:0];
            default: result = alu_a + alu_b;
        endcase
    end

    assign redirect_o.taken  = ex_q.valid && ex_q.branch && !load_use &&
                               ((op_a == op_b) != ex_q.branch_ne);
    assign redirect_o.target = ex_q.pc + 32'd4 + {ex_q.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_q.valid <= 1'b0;
        end else begin
            mem_q.valid      <= ex_q.valid && !load_use;
            mem_q.pc         <= ex_q.pc;
            mem_q.reg_write  <= ex_q.reg_write;
            mem_q.mem_read   <= ex_q.mem_read;
            mem_q.mem_write  <= ex_q.mem_write;
            mem_q.rd         <= ex_q.rd;
            mem_q.alu_result <= result;
            mem_q.store_data <= op_b;
        end
    end

    assign ex_stage_o = ex_q;
    assign ex_mem_o   = mem_q;

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Issue stage with register file
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              stall_i,
    input  wire logic              flush_i,
    input  wire mips_pkg::if_id_t  if_id_i,
    input  wire mips_pkg::wb_t     wb_i,
    output mips_pkg::id_ex_t       id_ex_o
);
    import mips_pkg::*;

    if_id_t    issue_q;
    word_t     rf [32];
    logic      known;
    logic      rf_we;
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t rs;
    reg_addr_t rt;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_q.valid <= 1'b0;
        end else if (flush_i) begin
            issue_q.valid <= 1'b0;
        end else if (!stall_i) begin
            issue_q <= if_id_i;
        end
    end

    assign op = issue_q.instr[31:26];
    assign fn = issue_q.instr[5:0];
    assign rs = issue_q.instr[25:21];
    assign rt = issue_q.instr[20:16];

    always_comb begin
        known               = 1'b0;
        id_ex_o.alu_op      = ALU_ADD;
        id_ex_o.imm_sel     = 1'b0;
        id_ex_o.shift_sel   = 1'b0;
        id_ex_o.reg_write   = 1'b0;
        id_ex_o.mem_read    = 1'b0;
        id_ex_o.mem_write   = 1'b0;
        id_ex_o.branch      = 1'b0;
        id_ex_o.branch_ne   = 1'b0;
        id_ex_o.rd          = '0;
        case (op)
            OP_RTYPE: begin
                known             = 1'b1;
                id_ex_o.reg_write = 1'b1;
                id_ex_o.rd        = issue_q.instr[15:11];
                case (fn)
                    FN_ADDU: id_ex_o.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_o.alu_op = ALU_SUB;
                    FN_AND:  id_ex_o.alu_op = ALU_AND;
                    FN_OR:   id_ex_o.alu_op = ALU_OR;
                    FN_SLT:  id_ex_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        id_ex_o.alu_op    = ALU_SLL;
                        id_ex_o.shift_sel = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                known             = 1'b1;
                id_ex_o.imm_sel   = 1'b1;
                id_ex_o.reg_write = 1'b1;
                id_ex_o.mem_read  = (op == OP_LW);
                id_ex_o.rd        = rt;
            end
            OP_SW: begin
                known             = 1'b1;
                id_ex_o.imm_sel   = 1'b1;
                id_ex_o.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                known             = 1'b1;
                id_ex_o.branch    = 1'b1;
                id_ex_o.branch_ne = (op == OP_BNE);
            end
            default: known = 1'b0;
        endcase
    end

    assign rf_we = wb_i.valid && wb_i.reg_write && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[wb_i.rd] <= wb_i.data;
        end
    end

    // Write-first read so writeback is seen in the same cycle
    assign id_ex_o.rs_data = (rs == '0) ? '0 : (rf_we && wb_i.rd == rs) ? wb_i.data : rf[rs];
    assign id_ex_o.rt_data = (rt == '0) ? '0 : (rf_we && wb_i.rd == rt) ? wb_i.data : rf[rt];

    assign id_ex_o.valid = issue_q.valid && known && !stall_i;
    assign id_ex_o.pc    = issue_q.pc;
    assign id_ex_o.rs    = rs;
    assign id_ex_o.rt    = rt;
    assign id_ex_o.imm   = {{16{issue_q.instr[15]}}, issue_q.instr[15:0]};
    assign id_ex_o.shamt = issue_q.instr[10:6];

    a_stall_flush: assert property (@(posedge clk) disable iff (!rst_n_i) !(stall_i && flush_i));

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
// Instruction fetch
`default_nettype none

module fetch_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 stall_i,
    input  wire mips_pkg::redirect_t  redirect_i,
    input  wire logic                 prog_we_i,
    input  wire mips_pkg::word_t      prog_addr_i,
    input  wire mips_pkg::word_t      prog_data_i,
    output mips_pkg::if_id_t          if_id_o
);
    import mips_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    word_t pc_q;
    word_t imem [IMEM_DEPTH];

    // Program load port takes byte addresses
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            imem[prog_addr_i[IMEM_AW+1:2]] <= prog_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // The issue register in decode captures this word
    assign if_id_o.valid = 1'b1;
    assign if_id_o.pc    = pc_q;
    assign if_id_o.instr = imem[pc_q[IMEM_AW+1:2]];

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== src/mips_pkg.sv ====
// MIPS core shared types
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLL  = 6'h00;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        logic      imm_sel;   // Operand B is the immediate
        logic      shift_sel; // Operand A is the shift amount
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;        // Destination, already chosen between rt and rd
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        logic [4:0] shamt;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire
